// File: video_pkg.sv
//////////////////////////////////////////////////
// video timing package
// 640x480 at 60 Hz display timing and coordinates
//////////////////////////////////////////////////

package video_pkg;

    localparam int CORDW = 10;              // coordinate width in bits

    // visible area
    localparam int H_RES = 640;
    localparam int V_RES = 480;

    // horizontal blanking, in pixels
    localparam int H_FP    = 16;
    localparam int H_SYNC  = 96;
    localparam int H_BP    = 48;
    localparam int H_TOTAL = H_RES + H_FP + H_SYNC + H_BP;  // 800

    // vertical blanking, in lines
    localparam int V_FP    = 10;
    localparam int V_SYNC  = 2;
    localparam int V_BP    = 33;
    localparam int V_TOTAL = V_RES + V_FP + V_SYNC + V_BP;  // 525

    // sync windows, inclusive
    localparam int HS_START = H_RES + H_FP;                 // 656
    localparam int HS_END   = H_RES + H_FP + H_SYNC - 1;    // 751
    localparam int VS_START = V_RES + V_FP;                 // 490
    localparam int VS_END   = V_RES + V_FP + V_SYNC - 1;    // 491

    typedef logic [CORDW-1:0] coord_t;      // screen x or y

    // one pixel slot of the raster, syncs active low
    typedef struct packed {
        coord_t sx;
        coord_t sy;
        logic   hsync;
        logic   vsync;
        logic   de;                         // visible area
        logic   line_start;                 // sx == 0
    } timing_t;

endpackage

// File: sprite_pkg.sv
//////////////////////////////////////////////////
// sprite package
// bitmap, scale, colour and sprite FSM states
//////////////////////////////////////////////////

package sprite_pkg;

    // bitmap size in sprite pixels
    localparam int SPR_W = 8;
    localparam int SPR_H = 8;

    localparam int SPR_SCALE = 2;                   // screen pixels per bitmap pixel

    localparam int SPR_LINES = SPR_H * SPR_SCALE;  // screen lines covered by the sprite

    // counter widths
    localparam int SPR_BIT_W   = $clog2(SPR_W);
    localparam int SPR_ROW_W   = $clog2(SPR_H);
    localparam int SPR_SCALE_W = $clog2(SPR_SCALE);

    // letter F, row 0 in the top byte, bit 7 leftmost
    //   .XXXXXX.
    //   .X......
    //   .X......
    //   .XXXXX..
    //   .X......
    //   .X......
    //   .X......
    //   ........
    localparam logic [SPR_W*SPR_H-1:0] SPR_BITMAP = 64'h7E40_407C_4040_4000;

    typedef logic [SPR_W-1:0]       spr_row_t;      // one bitmap row
    typedef logic [SPR_BIT_W-1:0]   spr_bit_t;      // column within a row
    typedef logic [SPR_ROW_W-1:0]   spr_row_idx_t;  // row within the bitmap
    typedef logic [SPR_SCALE_W-1:0] spr_scale_t;    // repeat count per bit

    typedef logic [3:0] channel_t;                  // one colour channel

    // 4 bits per channel, 12 bits in all
    typedef struct packed {
        channel_t r;
        channel_t g;
        channel_t b;
    } colour_t;

    typedef enum logic [1:0] {
        SPR_IDLE,                                   // no sprite on this line
        SPR_WAIT_X,                                 // row chosen, waiting for sx
        SPR_DRAW,                                   // shifting out the row
        SPR_LINE_DONE                               // row finished for this line
    } spr_state_t;

endpackage

// File: display_timings.sv
//////////////////////////////////////////////////
// display timing generator
// raster counters, syncs, data enable, line start
//////////////////////////////////////////////////

`timescale 1ns/1ps

module display_timings (
    input  logic               clk_pix,
    input  logic               rst_n,
    output video_pkg::timing_t timing
);

    video_pkg::coord_t sx_next;
    video_pkg::coord_t sy_next;

    // everything the raster needs at one coordinate
    function automatic video_pkg::timing_t decode(
        input video_pkg::coord_t x,
        input video_pkg::coord_t y
    );
        video_pkg::timing_t t;
        t.sx         = x;
        t.sy         = y;
        t.hsync      = ~(x >= video_pkg::HS_START && x <= video_pkg::HS_END);  // active low
        t.vsync      = ~(y >= video_pkg::VS_START && y <= video_pkg::VS_END);
        t.de         = (x < video_pkg::H_RES) && (y < video_pkg::V_RES);
        t.line_start = (x == '0);
        return t;
    endfunction

    // next raster position, counting from the registered one
    always_comb begin
        sx_next = timing.sx;
        sy_next = timing.sy;
        if (timing.sx == video_pkg::H_TOTAL - 1) begin
            sx_next = '0;                       // end of line
            if (timing.sy == video_pkg::V_TOTAL - 1) begin
                sy_next = '0;                   // end of frame
            end else begin
                sy_next = timing.sy + 1'b1;
            end
        end else begin
            sx_next = timing.sx + 1'b1;
        end
    end

    // outputs registered together, reset holds (0,0)
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            timing <= decode('0, '0);           // first cycle after release shows (0,0)
        end else begin
            timing <= decode(sx_next, sy_next);
        end
    end

endmodule

// File: sprite_engine.sv
//////////////////////////////////////////////////
// sprite engine
// draws the scaled bitmap at a per-frame position
//////////////////////////////////////////////////

`timescale 1ns/1ps

module sprite_engine (
    input  logic               clk_pix,
    input  logic               rst_n,
    input  video_pkg::timing_t timing,
    input  video_pkg::coord_t  spr_x,
    input  video_pkg::coord_t  spr_y,
    output logic               spr_pix      // one cycle behind timing
);

    video_pkg::coord_t pos_x;               // position held for the frame
    video_pkg::coord_t pos_y;
    video_pkg::coord_t x_ref;               // position in use this cycle
    video_pkg::coord_t y_ref;
    video_pkg::coord_t y_off;               // line offset into the sprite
    video_pkg::coord_t y_row;

    logic frame_start;
    logic row_hit;
    logic armed;                            // row loaded, start on x match
    logic drawing;
    logic pix_d;

    sprite_pkg::spr_row_idx_t row_idx;
    sprite_pkg::spr_row_t     bitmap_row;
    sprite_pkg::spr_row_t     row_bits;
    sprite_pkg::spr_row_t     row_cur;
    sprite_pkg::spr_row_t     row_d;
    sprite_pkg::spr_bit_t     bit_idx;
    sprite_pkg::spr_bit_t     bit_cur;
    sprite_pkg::spr_bit_t     bit_d;
    sprite_pkg::spr_scale_t   scale_cnt;
    sprite_pkg::spr_scale_t   scale_cur;
    sprite_pkg::spr_scale_t   scale_d;
    sprite_pkg::spr_state_t   state;
    sprite_pkg::spr_state_t   state_d;

    // position and bitmap row for the current line
    always_comb begin
        frame_start = timing.line_start && (timing.sy == '0);  // (0,0)
        x_ref       = frame_start ? spr_x : pos_x;  // new position counts from pixel (0,0)
        y_ref       = frame_start ? spr_y : pos_y;
        y_off       = timing.sy - y_ref;            // wraps high above the sprite
        row_hit     = (y_off < sprite_pkg::SPR_LINES);
        y_row       = video_pkg::coord_t'(y_off / sprite_pkg::SPR_SCALE);
        row_idx     = y_row[sprite_pkg::SPR_ROW_W-1:0];
        // row 0 sits in the top byte
        bitmap_row  = sprite_pkg::spr_row_t'(sprite_pkg::SPR_BITMAP >>
                      ((sprite_pkg::SPR_H - 1 - row_idx) * sprite_pkg::SPR_W));
    end

    // FSM and row shifter
    always_comb begin
        state_d   = state;
        row_d     = row_bits;
        bit_d     = bit_idx;
        scale_d   = scale_cnt;
        pix_d     = 1'b0;
        row_cur   = row_bits;
        bit_cur   = bit_idx;
        scale_cur = scale_cnt;
        armed     = (state == sprite_pkg::SPR_WAIT_X);
        drawing   = (state == sprite_pkg::SPR_DRAW);

        if (timing.line_start) begin
            // each line starts over, cuts a row running past the line end
            state_d = row_hit ? sprite_pkg::SPR_WAIT_X : sprite_pkg::SPR_IDLE;
            row_d   = bitmap_row;
            row_cur = bitmap_row;
            armed   = row_hit;
            drawing = 1'b0;
        end

        if (armed && timing.sx == x_ref) begin
            drawing   = 1'b1;               // first bit on the matching pixel
            bit_cur   = '0;
            scale_cur = '0;
        end

        if (drawing) begin
            pix_d = row_cur[sprite_pkg::SPR_W-1];   // leftmost bit out
            if (scale_cur == sprite_pkg::SPR_SCALE - 1) begin
                row_d   = row_cur << 1;             // next bit
                bit_d   = bit_cur + 1'b1;
                scale_d = '0;
                if (bit_cur == sprite_pkg::SPR_W - 1) begin
                    state_d = sprite_pkg::SPR_LINE_DONE;
                end else begin
                    state_d = sprite_pkg::SPR_DRAW;
                end
            end else begin
                row_d   = row_cur;                  // hold the bit another cycle
                bit_d   = bit_cur;
                scale_d = scale_cur + 1'b1;
                state_d = sprite_pkg::SPR_DRAW;
            end
        end
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            state     <= sprite_pkg::SPR_IDLE;
            bit_idx   <= '0;
            scale_cnt <= '0;
            pos_x     <= '0;
            pos_y     <= '0;
            spr_pix   <= 1'b0;
        end else begin
            state     <= state_d;
            bit_idx   <= bit_d;
            scale_cnt <= scale_d;
            spr_pix   <= pix_d;
            if (frame_start) begin
                pos_x <= spr_x;                     // sampled once per frame
                pos_y <= spr_y;
            end
        end
    end

    always_ff @(posedge clk_pix) begin
        row_bits <= row_d;                          // row shift register
    end

endmodule

// File: pixel_mixer.sv
//////////////////////////////////////////////////
// pixel mixer
// aligns timing to the sprite, registers VGA out
//////////////////////////////////////////////////

`timescale 1ns/1ps

module pixel_mixer (
    input  logic                clk_pix,
    input  logic                rst_n,
    input  video_pkg::timing_t  timing,
    input  logic                spr_pix,
    input  sprite_pkg::colour_t spr_colour,
    output logic                vga_hsync,
    output logic                vga_vsync,
    output sprite_pkg::colour_t vga
);

    video_pkg::timing_t timing_q;           // lines up with spr_pix

    // stage 1, match the sprite engine latency
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            timing_q <= video_pkg::timing_t'{
                sx:         '0,
                sy:         '0,
                hsync:      1'b1,           // syncs idle high
                vsync:      1'b1,
                de:         1'b0,
                line_start: 1'b0
            };
        end else begin
            timing_q <= timing;
        end
    end

    // stage 2, output register
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            vga_hsync <= 1'b1;
            vga_vsync <= 1'b1;
            vga       <= '0;
        end else begin
            vga_hsync <= timing_q.hsync;
            vga_vsync <= timing_q.vsync;
            vga       <= (timing_q.de && spr_pix) ? spr_colour : '0;  // black in blanking
        end
    end

endmodule

// File: sprite_display_top.sv
//////////////////////////////////////////////////
// sprite display top
// timing, sprite engine and mixer for 640x480
//////////////////////////////////////////////////

`timescale 1ns/1ps

module sprite_display_top (
    input  logic                clk_pix,
    input  logic                rst_n,
    input  video_pkg::coord_t   spr_x,      // sprite top left, taken at frame start
    input  video_pkg::coord_t   spr_y,
    input  sprite_pkg::colour_t spr_colour,
    output logic                vga_hsync,
    output logic                vga_vsync,
    output sprite_pkg::colour_t vga
);

    video_pkg::timing_t timing;             // raster bus
    logic               spr_pix;            // one cycle behind timing

    // raster source
    display_timings display_timings_inst (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .timing  (timing)
    );

    // sprite source
    sprite_engine sprite_engine_inst (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .timing  (timing),
        .spr_x   (spr_x),
        .spr_y   (spr_y),
        .spr_pix (spr_pix)
    );

    // combine and register, two cycles from timing to vga
    pixel_mixer pixel_mixer_inst (
        .clk_pix    (clk_pix),
        .rst_n      (rst_n),
        .timing     (timing),
        .spr_pix    (spr_pix),
        .spr_colour (spr_colour),
        .vga_hsync  (vga_hsync),
        .vga_vsync  (vga_vsync),
        .vga        (vga)
    );

endmodule

// File: tb_sprite_display.sv
//////////////////////////////////////////////////
// sprite display testbench
// frame by frame check of syncs, pixels, counts
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_sprite_display;

    localparam int NUM_VEC      = 8;            // lines in the vector file
    localparam int FRAME_CYCLES = video_pkg::H_TOTAL * video_pkg::V_TOTAL;
    localparam int WATCHDOG_NS  = (NUM_VEC + 2) * FRAME_CYCLES * 10 + 20000;

    // sync windows from the porches, upper bound exclusive
    localparam int HS_FIRST = video_pkg::H_RES + video_pkg::H_FP;
    localparam int HS_AFTER = HS_FIRST + video_pkg::H_SYNC;
    localparam int VS_FIRST = video_pkg::V_RES + video_pkg::V_FP;
    localparam int VS_AFTER = VS_FIRST + video_pkg::V_SYNC;

    logic                clk_pix;
    logic                rst_n;
    video_pkg::coord_t   spr_x;
    video_pkg::coord_t   spr_y;
    sprite_pkg::colour_t spr_colour;
    logic                vga_hsync;
    logic                vga_vsync;
    sprite_pkg::colour_t vga;

    logic [47:0] vectors [NUM_VEC];             // x, y, colour, lit count
    logic [31:0] rng;                           // xorshift state
    int          rx;                            // raster position now on vga
    int          ry;

    sprite_display_top sprite_display_top_inst (
        .clk_pix    (clk_pix),
        .rst_n      (rst_n),
        .spr_x      (spr_x),
        .spr_y      (spr_y),
        .spr_colour (spr_colour),
        .vga_hsync  (vga_hsync),
        .vga_vsync  (vga_vsync),
        .vga        (vga)
    );

    always #5 clk_pix = ~clk_pix;               // 100 MHz stand-in for the pixel clock

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // expected sprite bit at screen (x,y) for a sprite at (px,py)
    function automatic logic sprite_bit(input int x, input int y, input int px, input int py);
        int dx;
        int dy;
        int col;
        int row;
        dx = x - px;
        dy = y - py;
        if (x >= video_pkg::H_RES || y >= video_pkg::V_RES) begin
            return 1'b0;                        // nothing shows in blanking
        end
        if (dx < 0 || dx >= sprite_pkg::SPR_W * sprite_pkg::SPR_SCALE) begin
            return 1'b0;
        end
        if (dy < 0 || dy >= sprite_pkg::SPR_H * sprite_pkg::SPR_SCALE) begin
            return 1'b0;
        end
        col = dx / sprite_pkg::SPR_SCALE;       // each bit spans 2x2 pixels
        row = dy / sprite_pkg::SPR_SCALE;
        // row 0 in the top byte with column 0 as bit 7
        return sprite_pkg::SPR_BITMAP[(sprite_pkg::SPR_H - 1 - row) * sprite_pkg::SPR_W
                                      + (sprite_pkg::SPR_W - 1 - col)];
    endfunction

    task automatic abort_run;
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic check_colour(input string name, input sprite_pkg::colour_t got,
                                input sprite_pkg::colour_t exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%03h, expected 0x%03h at x %0d y %0d",
                     name, got, exp, rx, ry);
            abort_run();
        end
    endtask

    task automatic check_sync(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%0h, expected 0x%0h at x %0d y %0d",
                     name, got, exp, rx, ry);
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
            abort_run();
        end
    endtask

    // position and colour for one frame
    task automatic apply_vector(input int idx);
        spr_x      = vectors[idx][45:36];
        spr_y      = vectors[idx][33:24];
        spr_colour = sprite_pkg::colour_t'(vectors[idx][23:12]);
    endtask

    initial begin : run
        logic [47:0]         cur;
        int                  px;
        int                  py;
        int                  lit;
        int                  change_at;
        sprite_pkg::colour_t col;
        sprite_pkg::colour_t exp_colour;

        $readmemh("sprite_vectors.mem", vectors);
        rng     = 32'd96749;
        rx      = 0;
        ry      = 0;
        clk_pix = 1'b0;
        rst_n   = 1'b0;
        apply_vector(0);                        // frame 0 taken at the first (0,0)

        // idle outputs while in reset
        repeat (8) begin
            @(negedge clk_pix);
            check_colour("vga", vga, '0);
            check_sync("vga_hsync", vga_hsync, 1'b1);
            check_sync("vga_vsync", vga_vsync, 1'b1);
        end
        rst_n = 1'b1;
        @(negedge clk_pix);                     // (0,0) reaches vga on the next falling edge

        for (int f = 0; f < NUM_VEC; f++) begin
            cur       = vectors[f];
            px        = int'(cur[45:36]);
            py        = int'(cur[33:24]);
            col       = sprite_pkg::colour_t'(cur[23:12]);
            lit       = 0;
            rng       = xorshift(rng);
            // before the sprite's second line, so the move would still show
            change_at = int'(rng % (video_pkg::H_TOTAL * (py + 1)));
            for (ry = 0; ry < video_pkg::V_TOTAL; ry++) begin
                for (rx = 0; rx < video_pkg::H_TOTAL; rx++) begin
                    @(negedge clk_pix);
                    exp_colour = sprite_bit(rx, ry, px, py) ? col : '0;
                    check_colour("vga", vga, exp_colour);
                    check_sync("vga_hsync", vga_hsync,
                               !(rx >= HS_FIRST && rx < HS_AFTER));
                    check_sync("vga_vsync", vga_vsync,
                               !(ry >= VS_FIRST && ry < VS_AFTER));
                    if (vga != '0) begin
                        lit++;
                    end
                    // mid-frame move must not show before the next frame
                    if (ry * video_pkg::H_TOTAL + rx == change_at) begin
                        rng   = xorshift(rng);
                        spr_x = rng[9:0];
                        spr_y = rng[25:16];
                    end
                    // next frame's vector during vertical blanking
                    if (ry == video_pkg::V_RES && rx == 0 && f + 1 < NUM_VEC) begin
                        apply_vector(f + 1);
                    end
                end
            end
            check_count("lit pixels", lit, int'(cur[11:0]));
            $display("frame %0d checked, %0d lit pixels", f, lit);
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

    // bound on run length with two spare frames
    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout, frames not finished after %0d ns", WATCHDOG_NS);
        $display("TEST RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: sprite_vectors.mem
// columns: spr_x _ spr_y _ colour rgb _ expected lit pixels, all hex
// one line per frame, applied in the blanking of the frame before
064_050_F00_040
27C_0C8_0F0_01C
000_000_00F_040
130_1D8_FF0_034
1F0_0F0_000_000
270_1D0_0FF_040
3E8_064_F0F_000
140_0F0_FFF_040

// File: compile.f
video_pkg.sv
sprite_pkg.sv
display_timings.sv
sprite_engine.sv
pixel_mixer.sv
sprite_display_top.sv
tb_sprite_display.sv

// File: Makefile
# Verilator build and run of the sprite display testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --top-module tb_sprite_display -f compile.f -o tb_sim
	./obj_dir/tb_sim | tee /dev/stderr | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir
